// File: Bender.yml
package:
  name: axil_timer

sources:
  - source/axil_pkg.sv
  - source/axil_simple_bridge.sv
  - source/timer_regs.sv
  - source/timer_core.sv
  - source/axil_timer_top.sv
  - target: test
    files:
      - testbench/axil_bridge_checker.sv
      - testbench/axil_timer_tb.sv

// File: source/axil_pkg.sv
`default_nettype none

package axil_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_WIDTH = 12;
    localparam int ID_WIDTH   = 4;
    localparam int DATA_WIDTH = 32;              // Fixed, the register bus is 32 bit
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Register map, byte offsets
    localparam logic [ADDR_WIDTH-1:0] REG_SCRATCH = 12'h000;
    localparam logic [ADDR_WIDTH-1:0] REG_CTRL    = 12'h004;
    localparam logic [ADDR_WIDTH-1:0] REG_RELOAD  = 12'h008;
    localparam logic [ADDR_WIDTH-1:0] REG_COUNT   = 12'h00C; // Read only
    localparam logic [ADDR_WIDTH-1:0] REG_STATUS  = 12'h010; // Read only

    // Bit positions inside CTRL and STATUS
    localparam int CTRL_ENABLE_BIT      = 0;
    localparam int CTRL_AUTO_RELOAD_BIT = 1;
    localparam int STATUS_EXPIRED_BIT   = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESPOND,
        READ_RESPOND
    } bridge_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // AXI channel payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [ID_WIDTH-1:0]   id;
        logic [7:0]            len;   // Bursts are not supported
        logic [2:0]            size;
        logic [1:0]            burst;
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } axil_w_t;

    typedef struct packed {
        axi_resp_e             resp;
        logic [ID_WIDTH-1:0]   id;
    } axil_b_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [ID_WIDTH-1:0]   id;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axil_ar_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        axi_resp_e             resp;
        logic [ID_WIDTH-1:0]   id;
        logic                  last;
    } axil_r_t;

    // Simple register bus
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic                  write;            // One cycle strobe
        logic                  read;             // One cycle strobe
        logic [DATA_WIDTH-1:0] write_data;
        logic [STRB_WIDTH-1:0] write_byteenable;
    } simple_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] read_data;
        logic                  address_error;
        logic                  write_error;
    } simple_rsp_t;

    // Register block to timer core and back
    typedef struct packed {
        logic                  enable;
        logic                  auto_reload;
        logic [DATA_WIDTH-1:0] reload;
        logic                  load;           // Pulse
        logic                  clear_expired;  // Pulse
    } timer_cfg_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] count;
        logic                  expired;
    } timer_stat_t;

endpackage

`default_nettype wire

// File: source/axil_simple_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module axil_simple_bridge
    import axil_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,

    // Write address channel
    input  wire           awvalid,
    output logic          awready,
    input  wire axil_aw_t aw,

    // Write data channel
    input  wire           wvalid,
    output logic          wready,
    input  wire axil_w_t  w,

    // Write response channel
    output logic          bvalid,
    input  wire           bready,
    output axil_b_t       b,

    // Read address channel
    input  wire           arvalid,
    output logic          arready,
    input  wire axil_ar_t ar,

    // Read data channel
    output logic          rvalid,
    input  wire           rready,
    output axil_r_t       r,

    // Simple register bus
    output simple_req_t   req,
    input  wire simple_rsp_t rsp
);

    bridge_state_e         state_q;
    bridge_state_e         state_d;

    logic                  write_accept;
    logic                  read_accept;

    // Response payload, latched at the accept edge
    logic [ID_WIDTH-1:0]   id_q;
    axi_resp_e             resp_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    axi_resp_e             write_resp;
    axi_resp_e             read_resp;

    ////////////////////////////////////////////////////////////////////////////
    // Accept decisions
    ////////////////////////////////////////////////////////////////////////////

    // A write needs both address and data; it always wins over a read
    assign write_accept = (state_q == IDLE) && awvalid && wvalid;
    assign read_accept  = (state_q == IDLE) && arvalid && !awvalid;

    assign awready = write_accept;
    assign wready  = write_accept;
    assign arready = read_accept;

    assign bvalid = (state_q == WRITE_RESPOND);
    assign rvalid = (state_q == READ_RESPOND);

    // Request toward the register block
    always_comb begin
        req.address          = awvalid ? aw.addr : ar.addr;
        req.write            = write_accept;
        req.read             = read_accept;
        req.write_data       = w.data;      // Passed straight through
        req.write_byteenable = w.strb;
    end

    // Response codes from the register block's decode
    always_comb begin
        if (rsp.address_error) begin
            write_resp = DECERR;
        end else if (rsp.write_error) begin
            write_resp = SLVERR;
        end else begin
            write_resp = OKAY;
        end
        read_resp = rsp.address_error ? DECERR : OKAY;
    end

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (write_accept) begin
                    state_d = WRITE_RESPOND;
                end else if (read_accept) begin
                    state_d = READ_RESPOND;
                end
            end
            WRITE_RESPOND: begin
                if (bready) begin
                    state_d = IDLE;                  // Back to IDLE after B handshake
                end
            end
            READ_RESPOND: begin
                if (rready) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload only changes on accept, so it stays stable under back-pressure
    always_ff @(posedge clk) begin
        if (write_accept) begin
            id_q   <= aw.id;
            resp_q <= write_resp;
        end else if (read_accept) begin
            id_q    <= ar.id;
            resp_q  <= read_resp;
            rdata_q <= rsp.read_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response channels
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        b.resp = resp_q;
        b.id   = id_q;

        r.data = rdata_q;
        r.resp = resp_q;
        r.id   = id_q;
        r.last = 1'b1;                            // Single beat only
    end

endmodule

`default_nettype wire

// File: source/axil_timer_top.sv
`timescale 1ns/100ps
`default_nettype none

module axil_timer_top
    import axil_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,

    input  wire           awvalid,
    output logic          awready,
    input  wire axil_aw_t aw,

    input  wire           wvalid,
    output logic          wready,
    input  wire axil_w_t  w,

    output logic          bvalid,
    input  wire           bready,
    output axil_b_t       b,

    input  wire           arvalid,
    output logic          arready,
    input  wire axil_ar_t ar,

    output logic          rvalid,
    input  wire           rready,
    output axil_r_t       r,

    output logic          irq
);

    simple_req_t req;
    simple_rsp_t rsp;
    timer_cfg_t  cfg;
    timer_stat_t stat;

    ////////////////////////////////////////////////////////////////////////////
    // AXI slave bridge, register block, timer
    ////////////////////////////////////////////////////////////////////////////

    axil_simple_bridge u_bridge (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .b       (b),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r),
        .req     (req),
        .rsp     (rsp)
    );

    timer_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp),
        .cfg   (cfg),
        .stat  (stat)
    );

    timer_core u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg),
        .stat  (stat)
    );

    assign irq = stat.expired;               // Sticky until a STATUS read

endmodule

`default_nettype wire

// File: source/timer_core.sv
`timescale 1ns/100ps
`default_nettype none

module timer_core
    import axil_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,

    input  wire timer_cfg_t cfg,
    output timer_stat_t     stat
);

    logic [DATA_WIDTH-1:0] count_q;
    logic                  expired_q;
    logic                  count_zero;
    logic                  reaching_zero;

    assign count_zero = (count_q == '0);

    // Last decrement this cycle, so count reads zero in the next one
    assign reaching_zero = cfg.enable && !cfg.load && (count_q == DATA_WIDTH'(1));

    ////////////////////////////////////////////////////////////////////////////
    // Down counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_n) begin
            count_q <= '0;
        end else if (cfg.load) begin
            count_q <= cfg.reload;
        end else if (cfg.enable) begin
            if (!count_zero) begin
                count_q <= count_q - DATA_WIDTH'(1);
            end else if (cfg.auto_reload) begin
                count_q <= cfg.reload;             // One cycle at zero, then reload
            end
        end
    end

    // Sticky expiry flag; a new expiry beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst_n) begin
            expired_q <= 1'b0;
        end else if (reaching_zero) begin
            expired_q <= 1'b1;
        end else if (cfg.clear_expired) begin
            expired_q <= 1'b0;
        end
    end

    always_comb begin
        stat.count   = count_q;
        stat.expired = expired_q;
    end

endmodule

`default_nettype wire

// File: source/timer_regs.sv
`timescale 1ns/100ps
`default_nettype none

module timer_regs
    import axil_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    input  wire simple_req_t req,
    output simple_rsp_t      rsp,

    output timer_cfg_t       cfg,
    input  wire timer_stat_t stat
);

    logic                  hit_scratch;
    logic                  hit_ctrl;
    logic                  hit_reload;
    logic                  hit_count;
    logic                  hit_status;
    logic                  read_only;
    logic                  ctrl_write;

    logic [DATA_WIDTH-1:0] scratch_q;
    logic [DATA_WIDTH-1:0] reload_q;
    logic                  enable_q;
    logic                  auto_reload_q;

    // Word match, the two low address bits are ignored
    function automatic logic word_match(
        input logic [ADDR_WIDTH-1:0] address,
        input logic [ADDR_WIDTH-1:0] offset
    );
        return address[ADDR_WIDTH-1:2] == offset[ADDR_WIDTH-1:2];
    endfunction

    // Byte lane merge under write enables
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(
        input logic [DATA_WIDTH-1:0] old_value,
        input logic [DATA_WIDTH-1:0] new_value,
        input logic [STRB_WIDTH-1:0] strb
    );
        logic [DATA_WIDTH-1:0] result;
        result = old_value;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_value[8*i +: 8];
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    assign hit_scratch = word_match(req.address, REG_SCRATCH);
    assign hit_ctrl    = word_match(req.address, REG_CTRL);
    assign hit_reload  = word_match(req.address, REG_RELOAD);
    assign hit_count   = word_match(req.address, REG_COUNT);
    assign hit_status  = word_match(req.address, REG_STATUS);
    assign read_only   = hit_count || hit_status;

    // CTRL lives in byte 0
    assign ctrl_write = req.write && hit_ctrl && req.write_byteenable[0];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            scratch_q     <= '0;
            reload_q      <= '0;
            enable_q      <= 1'b0;
            auto_reload_q <= 1'b0;
        end else begin
            if (req.write && hit_scratch) begin
                scratch_q <= merge_bytes(scratch_q, req.write_data, req.write_byteenable);
            end
            if (req.write && hit_reload) begin
                reload_q <= merge_bytes(reload_q, req.write_data, req.write_byteenable);
            end
            if (ctrl_write) begin
                enable_q      <= req.write_data[CTRL_ENABLE_BIT];
                auto_reload_q <= req.write_data[CTRL_AUTO_RELOAD_BIT];
            end
        end
    end

    // Configuration and pulses to the timer core
    always_comb begin
        cfg.enable        = enable_q;
        cfg.auto_reload   = auto_reload_q;
        cfg.reload        = reload_q;
        cfg.load          = ctrl_write && req.write_data[CTRL_ENABLE_BIT];
        cfg.clear_expired = req.read && hit_status;   // Takes effect at the accept edge
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read mux and error flags
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rsp.read_data     = '0;                    // Unmapped reads return zero
        rsp.address_error = 1'b0;
        rsp.write_error   = req.write && read_only;
        if (hit_scratch) begin
            rsp.read_data = scratch_q;
        end else if (hit_ctrl) begin
            rsp.read_data[CTRL_ENABLE_BIT]      = enable_q;
            rsp.read_data[CTRL_AUTO_RELOAD_BIT] = auto_reload_q;
        end else if (hit_reload) begin
            rsp.read_data = reload_q;
        end else if (hit_count) begin
            rsp.read_data = stat.count;
        end else if (hit_status) begin
            rsp.read_data[STATUS_EXPIRED_BIT] = stat.expired;
        end else begin
            rsp.address_error = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: testbench/axil_bridge_checker.sv
`timescale 1ns/100ps
`default_nettype none

module axil_bridge_checker
    import axil_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           awvalid,
    input  wire           awready,
    input  wire axil_aw_t aw,
    input  wire           wready,
    input  wire           arready,
    input  wire           bvalid,
    input  wire           bready,
    input  wire axil_b_t  b,
    input  wire           rvalid,
    input  wire           rready,
    input  wire axil_r_t  r
);

    int                  error_count = 0;   // Assertion failures seen so far
    logic [ID_WIDTH-1:0] last_awid;

    // ID of the most recent write accept
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            last_awid <= aw.id;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response channel rules
    ////////////////////////////////////////////////////////////////////////////

    responses_exclusive: assert property (@(posedge clk) disable iff (rst_n)
        !(bvalid && rvalid))
        else begin
            error_count++;
            $error("bvalid and rvalid high together");
        end

    b_held: assert property (@(posedge clk) disable iff (rst_n)
        bvalid && !bready |=> bvalid && $stable(b))
        else begin
            error_count++;
            $error("B channel changed before bready");
        end

    r_held: assert property (@(posedge clk) disable iff (rst_n)
        rvalid && !rready |=> rvalid && $stable(r))
        else begin
            error_count++;
            $error("R channel changed before rready");
        end

    bid_matches: assert property (@(posedge clk) disable iff (rst_n)
        bvalid |-> b.id == last_awid)
        else begin
            error_count++;
            $error("bid differs from the accepted awid");
        end

    rlast_high: assert property (@(posedge clk) disable iff (rst_n) r.last)
        else begin
            error_count++;
            $error("rlast is low");
        end

    // Quiet handshake outputs right after a reset cycle
    quiet_after_reset: assert property (@(posedge clk)
        rst_n |=> !awready && !wready && !arready && !bvalid && !rvalid)
        else begin
            error_count++;
            $error("handshake output high after reset");
        end

endmodule

bind axil_simple_bridge axil_bridge_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .aw      (aw),
    .wready  (wready),
    .arready (arready),
    .bvalid  (bvalid),
    .bready  (bready),
    .b       (b),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r)
);

`default_nettype wire

// File: testbench/axil_timer_tb.sv
`timescale 1ns/100ps
`default_nettype none

module axil_timer_tb
    import axil_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int MAX_ENTRIES = 32;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT} op_e;
    typedef enum logic [1:0] {CHK_EXACT, CHK_RANGE, CHK_AT_MOST} chk_e;

    // For OP_WAIT, data is the cycle count and exp_data[0] the expected irq
    typedef struct packed {
        op_e                   op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        axi_resp_e             resp;
        logic [DATA_WIDTH-1:0] exp_data;
        chk_e                  kind;
    } entry_t;

    logic     clk;
    logic     rst_n;
    logic     awvalid, awready, wvalid, wready, bvalid, bready;
    logic     arvalid, arready, rvalid, rready;
    axil_aw_t aw;
    axil_w_t  w;
    axil_b_t  b;
    axil_ar_t ar;
    axil_r_t  r;
    logic     irq;

    entry_t   entries [MAX_ENTRIES];
    int       num_entries  = 0;
    int       fail_count   = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;

    axil_timer_top uut (
        .clk(clk), .rst_n(rst_n),
        .awvalid(awvalid), .awready(awready), .aw(aw),
        .wvalid(wvalid), .wready(wready), .w(w),
        .bvalid(bvalid), .bready(bready), .b(b),
        .arvalid(arvalid), .arready(arready), .ar(ar),
        .rvalid(rvalid), .rready(rready), .r(r),
        .irq(irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reporting helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        fail_count++;
    endtask

    task automatic report_out_of_range(input string name, input logic [31:0] got,
                                       input logic [31:0] low, input logic [31:0] high);
        $display("FAIL %s got 0x%0h outside 0x%0h..0x%0h", name, got, low, high);
        fail_count++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        fail_count++;
    endtask

    task automatic report_test(input int index, input string what, input int errors_before);
        if (fail_count == errors_before) begin
            tests_passed++;
            $display("test %0d %s: ok", index, what);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", index, what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI master, called right after a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_register(input logic [ADDR_WIDTH-1:0] addr,
                                  input logic [DATA_WIDTH-1:0] data,
                                  input logic [STRB_WIDTH-1:0] strb,
                                  input logic [ID_WIDTH-1:0] id, input int hold,
                                  output axil_b_t resp);
        axil_b_t held;
        logic    accepted;
        aw.addr = addr;
        aw.id   = id;
        w.data  = data;
        w.strb  = strb;
        w.last  = 1'b1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do begin
            #(CLK_PERIOD / 4);                 // Ready is settled mid low phase
            accepted = awready && wready;
            if (awready !== wready) report_mismatch("wready", wready, awready);
            @(negedge clk);
        end while (!accepted);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) report_error("bvalid not high the cycle after the write accept");
        while (!bvalid) @(negedge clk);
        held    = b;
        repeat (hold) begin
            @(negedge clk);
            if (!bvalid) report_error("bvalid dropped while bready was low");
            if (b !== held) report_mismatch("b", b, held);
        end
        bready = 1'b1;
        resp   = b;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_register(input logic [ADDR_WIDTH-1:0] addr,
                                 input logic [ID_WIDTH-1:0] id, input int hold,
                                 output axil_r_t resp);
        axil_r_t held;
        logic    accepted;
        ar.addr = addr;
        ar.id   = id;
        arvalid = 1'b1;
        do begin
            #(CLK_PERIOD / 4);
            accepted = arready;
            @(negedge clk);
        end while (!accepted);
        arvalid = 1'b0;
        if (!rvalid) report_error("rvalid not high the cycle after the read accept");
        while (!rvalid) @(negedge clk);
        held    = r;
        repeat (hold) begin
            @(negedge clk);
            if (!rvalid) report_error("rvalid dropped while rready was low");
            if (r !== held) report_mismatch("r", r, held);
        end
        rready = 1'b1;
        resp   = r;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        logic [ID_WIDTH-1:0] id;
        axil_b_t             bresp;
        axil_r_t             rresp;
        id = ID_WIDTH'($urandom_range(0, 15));
        case (e.op)
            OP_WRITE: begin
                write_register(e.addr, e.data, e.strb, id, $urandom_range(0, 3), bresp);
                if (bresp.resp !== e.resp) report_mismatch("bresp", bresp.resp, e.resp);
                if (bresp.id !== id) report_mismatch("bid", bresp.id, id);
            end
            OP_READ: begin
                read_register(e.addr, id, $urandom_range(0, 3), rresp);
                if (rresp.resp !== e.resp) report_mismatch("rresp", rresp.resp, e.resp);
                if (rresp.id !== id) report_mismatch("rid", rresp.id, id);
                if (e.kind == CHK_EXACT && rresp.data !== e.exp_data)
                    report_mismatch("rdata", rresp.data, e.exp_data);
                if (e.kind == CHK_RANGE && (rresp.data == 0 || rresp.data > e.exp_data))
                    report_out_of_range("rdata", rresp.data, 1, e.exp_data);
                if (e.kind == CHK_AT_MOST && rresp.data > e.exp_data)
                    report_out_of_range("rdata", rresp.data, 0, e.exp_data);
            end
            default: begin
                repeat (e.data) @(negedge clk);
                if (irq !== e.exp_data[0]) report_mismatch("irq", irq, e.exp_data[0]);
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_entry(input op_e op, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data,
                             input logic [STRB_WIDTH-1:0] strb, input axi_resp_e resp,
                             input logic [DATA_WIDTH-1:0] exp_data, input chk_e kind);
        entry_t e;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.strb     = strb;
        e.resp     = resp;
        e.exp_data = exp_data;
        e.kind     = kind;
        entries[num_entries] = e;
        num_entries++;
    endtask

    task automatic build_table();
        logic [DATA_WIDTH-1:0] first_value;
        logic [DATA_WIDTH-1:0] second_value;
        logic [DATA_WIDTH-1:0] merged;
        first_value  = $urandom();
        second_value = $urandom();
        merged       = (first_value & 32'hFF00_FF00) | (second_value & 32'h00FF_00FF);
        // Scratch round trip, then a write to bytes 0 and 2 only
        add_entry(OP_WRITE, REG_SCRATCH, first_value, 4'hF, OKAY, 0, CHK_EXACT);
        add_entry(OP_READ, REG_SCRATCH, 0, 4'h0, OKAY, first_value, CHK_EXACT);
        add_entry(OP_WRITE, REG_SCRATCH, second_value, 4'b0101, OKAY, 0, CHK_EXACT);
        add_entry(OP_READ, REG_SCRATCH, 0, 4'h0, OKAY, merged, CHK_EXACT);
        // Error responses
        add_entry(OP_READ, 12'h020, 0, 4'h0, DECERR, 0, CHK_EXACT);
        add_entry(OP_WRITE, 12'h7FC, 32'h1234_5678, 4'hF, DECERR, 0, CHK_EXACT);
        add_entry(OP_WRITE, REG_COUNT, 32'hDEAD_BEEF, 4'hF, SLVERR, 0, CHK_EXACT);
        add_entry(OP_READ, REG_COUNT, 0, 4'h0, OKAY, 0, CHK_EXACT);
        add_entry(OP_WRITE, REG_STATUS, 32'h1, 4'hF, SLVERR, 0, CHK_EXACT);
        add_entry(OP_READ, REG_STATUS, 0, 4'h0, OKAY, 0, CHK_EXACT);
        add_entry(OP_READ, REG_SCRATCH, 0, 4'h0, OKAY, merged, CHK_EXACT);
        // One-shot countdown from 100
        add_entry(OP_WRITE, REG_RELOAD, 32'd100, 4'hF, OKAY, 0, CHK_EXACT);
        add_entry(OP_WRITE, REG_CTRL, 32'h1, 4'hF, OKAY, 0, CHK_EXACT);
        add_entry(OP_READ, REG_CTRL, 0, 4'h0, OKAY, 32'h1, CHK_EXACT);
        add_entry(OP_READ, REG_COUNT, 0, 4'h0, OKAY, 32'd100, CHK_RANGE);
        add_entry(OP_WAIT, 12'h000, 32'd110, 4'h0, OKAY, 32'h1, CHK_EXACT);
        add_entry(OP_READ, REG_COUNT, 0, 4'h0, OKAY, 0, CHK_EXACT);
        add_entry(OP_READ, REG_STATUS, 0, 4'h0, OKAY, 32'h1, CHK_EXACT);
        add_entry(OP_WAIT, 12'h000, 32'd1, 4'h0, OKAY, 32'h0, CHK_EXACT);
        add_entry(OP_READ, REG_STATUS, 0, 4'h0, OKAY, 0, CHK_EXACT);
        // Auto-reload with a period of 9 cycles
        add_entry(OP_WRITE, REG_RELOAD, 32'd8, 4'hF, OKAY, 0, CHK_EXACT);
        add_entry(OP_WRITE, REG_CTRL, 32'h3, 4'hF, OKAY, 0, CHK_EXACT);
        add_entry(OP_WAIT, 12'h000, 32'd12, 4'h0, OKAY, 32'h1, CHK_EXACT);
        add_entry(OP_READ, REG_COUNT, 0, 4'h0, OKAY, 32'd8, CHK_AT_MOST);
        add_entry(OP_READ, REG_STATUS, 0, 4'h0, OKAY, 32'h1, CHK_EXACT);
        add_entry(OP_WAIT, 12'h000, 32'd12, 4'h0, OKAY, 32'h1, CHK_EXACT);
        add_entry(OP_WRITE, REG_CTRL, 32'h0, 4'hF, OKAY, 0, CHK_EXACT);
        add_entry(OP_READ, REG_STATUS, 0, 4'h0, OKAY, 32'h1, CHK_EXACT);
        add_entry(OP_WAIT, 12'h000, 32'd2, 4'h0, OKAY, 32'h0, CHK_EXACT);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Back-pressure and write priority
    ////////////////////////////////////////////////////////////////////////////

    task automatic hold_response_check();
        logic [ID_WIDTH-1:0] id;
        axil_b_t             bresp;
        id = ID_WIDTH'($urandom_range(0, 15));
        write_register(REG_SCRATCH, 32'hA5A5_0F0F, 4'hF, id, 8, bresp);   // Held 8 cycles
        if (bresp.resp !== OKAY) report_mismatch("bresp", bresp.resp, OKAY);
        if (bresp.id !== id) report_mismatch("bid", bresp.id, id);
    endtask

    task automatic write_before_read();
        logic [DATA_WIDTH-1:0] value;
        axil_b_t               bresp;
        axil_r_t               rresp;
        value   = $urandom();
        aw.addr = REG_SCRATCH;
        aw.id   = 4'h3;
        w.data  = value;
        w.strb  = 4'hF;
        ar.addr = REG_SCRATCH;
        ar.id   = 4'hC;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        arvalid = 1'b1;
        #(CLK_PERIOD / 4);
        if (!(awready && wready)) report_error("write not accepted beside a pending read");
        if (arready) report_error("read accepted in the same cycle as a write");
        @(negedge clk);
        while (!bvalid && !rvalid) @(negedge clk);
        if (rvalid) report_error("read answered before the pending write");
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (bvalid) begin
            bready = 1'b1;
            bresp  = b;
            @(negedge clk);
            bready = 1'b0;
            if (bresp.resp !== OKAY) report_mismatch("bresp", bresp.resp, OKAY);
            if (bresp.id !== 4'h3) report_mismatch("bid", bresp.id, 4'h3);
        end
        while (!rvalid) @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        rresp   = r;
        @(negedge clk);
        rready  = 1'b0;
        if (rresp.data !== value) report_mismatch("rdata", rresp.data, value);
        if (rresp.id !== 4'hC) report_mismatch("rid", rresp.id, 4'hC);
    endtask

    // Watchdog, 200 cycles per test
    initial begin
        wait (num_entries > 0);
        #((num_entries + 2) * 200 * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int errors_before;
        void'($urandom(12786));   // Seed the generator once
        clk     = 1'b0;
        rst_n   = 1'b1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        bready  = 1'b0;
        rready  = 1'b0;
        aw      = '0;
        w       = '0;
        ar      = '0;
        aw.size = 3'd2;
        ar.size = 3'd2;
        build_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b0;
        @(negedge clk);

        for (int i = 0; i < num_entries; i++) begin
            errors_before = fail_count;
            apply_entry(entries[i]);
            report_test(i, $sformatf("%s 0x%03h", entries[i].op.name(), entries[i].addr),
                        errors_before);
        end
        errors_before = fail_count;
        hold_response_check();
        report_test(num_entries, "bready back-pressure", errors_before);
        errors_before = fail_count;
        write_before_read();
        report_test(num_entries + 1, "write before read", errors_before);

        repeat (2) @(negedge clk);
        fail_count += uut.u_bridge.u_checker.error_count;
        $display("%0d tests, %0d passed, %0d failed, %0d errors incl. %0d assertion failures",
                 tests_passed + tests_failed, tests_passed, tests_failed, fail_count,
                 uut.u_bridge.u_checker.error_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/axil_pkg.sv
source/axil_simple_bridge.sv
source/timer_regs.sv
source/timer_core.sv
source/axil_timer_top.sv
testbench/axil_bridge_checker.sv
testbench/axil_timer_tb.sv
